// ==== Bender.yml ====
package:
  name: rename_subsystem

sources:
  - hw/renamePkg.sv
  - hw/stageIf.sv
  - hw/uopQueue.sv
  - hw/renameStage.sv
  - hw/retireBuffer.sv
  - hw/renameTop.sv
  - target: test
    files:
      - dv/renameTop_sva.sv
      - dv/renameTb.sv

// ==== compile.f ====
hw/renamePkg.sv
hw/stageIf.sv
hw/uopQueue.sv
hw/renameStage.sv
hw/retireBuffer.sv
hw/renameTop.sv
dv/renameTop_sva.sv
dv/renameTb.sv

// ==== dv/renameTb.sv ====
module renameTb import renamePkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int QUEUE_DEPTH = 4;
    localparam int ROB_DEPTH = 8;
    localparam int CLK_PERIOD = 4;

    // Ops lost in a flush plus ops in flight after it, with some margin
    localparam int WB_SPAN = 2 * (ROB_DEPTH + 1) + 6;

    localparam int RANDOM_OPS = 40;
    localparam int FLUSH_OPS = 20;

    // Queue, rename slot and retire buffer all full
    localparam int PIPE_CAPACITY = QUEUE_DEPTH + ROB_DEPTH + 1;

    // Watchdog budget
    localparam int OP_BUDGET = RANDOM_OPS + 2 * FLUSH_OPS + 2 * PIPE_CAPACITY;
    localparam int CYCLES_PER_OP = 100;

    typedef struct packed {
        tag_t  tagA;
        srcB_t srcB;
        tag_t  freed;
    } expected_t;

    typedef struct packed {
        logic    isImm;
        opWord_u word;
    } opRec_t;

    logic    clk;
    logic    rst;
    logic    flush;
    logic    inValid;
    logic    inIsImm;
    opWord_u inWord;
    logic    inReady;
    logic    wbValid;
    seqNum_t wbSqN;
    logic    retValid;
    seqNum_t retSqN;
    regIdx_t retRd;
    tag_t    retTag;
    tag_t    retFreedTag;
    tag_t    retTagA;
    srcB_t   retSrcB;
    logic    retIsImm;

    // Committed map as seen from the retire port
    tag_t    refMap [NUM_ARCH_REGS];
    opRec_t  pending [$];
    seqNum_t lastSqN;
    logic    afterFlush;
    logic    wbEnable;

    string testName;
    int    errorCount;
    int    testErrors;
    int    retiredCount;
    int    testsRun;
    int    testsFailed;

    renameTop #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .ROB_DEPTH  (ROB_DEPTH)
    ) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(OP_BUDGET * CYCLES_PER_OP * CLK_PERIOD);
        $display("Watchdog expired in test %s with %0d operations not retired",
                 testName, pending.size());
        $display("Simulation failed");
        $finish;
    end

    // Expected operands and released tag from the committed map before update
    function automatic expected_t predictRetire(input logic isImm, input opWord_u word);
        expected_t e;
        regIdx_t   rd;
        rd = word.regForm.rd;
        e.tagA = refMap[word.regForm.rs1];
        e.srcB = isImm ? word.immForm.imm : refMap[word.regForm.rs2];
        e.freed = (rd != '0) ? refMap[rd] : '0;
        return e;
    endfunction

    task automatic reportMismatch(input string field, input int expVal, input int actVal);
        $display("Error %s: %s expected %0d, actual %0d", testName, field, expVal, actVal);
        errorCount++;
    endtask

    task automatic driveRandomOp(input int idx);
        inIsImm = 1'($urandom_range(1));
        inWord = 16'($urandom);
        // Every seventh op writes x0
        if (idx % 7 == 3) begin
            inWord.regForm.rd = '0;
        end
    endtask

    task automatic sendOp(input int idx);
        @(negedge clk);
        inValid = 1'b0;
        while (!inReady) begin
            @(negedge clk);
        end
        driveRandomOp(idx);
        inValid = 1'b1;
    endtask

    // Push ops until the queue refuses one
    task automatic floodQueue(output int accepted);
        accepted = 0;
        @(negedge clk);
        while (inReady) begin
            driveRandomOp(accepted);
            inValid = 1'b1;
            @(negedge clk);
            accepted++;
        end
        inValid = 1'b0;
    endtask

    task automatic applyFlush();
        @(negedge clk);
        inValid = 1'b0;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic waitDrain();
        @(negedge clk);
        inValid = 1'b0;
        while (pending.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic startTest(input string name);
        testName = name;
        testErrors = errorCount;
        testsRun++;
    endtask

    task automatic finishTest();
        int errs;
        errs = errorCount - testErrors;
        if (errs != 0) begin
            testsFailed++;
        end
        $display("Test %s %s with %0d errors, %0d retired so far",
                 testName, (errs == 0) ? "passed" : "failed", errs, retiredCount);
    endtask

    // Writebacks in random order over the window of possibly live sqNs
    task automatic driveWritebacks();
        logic en;
        forever begin
            @(posedge clk);
            en = wbEnable;
            @(negedge clk);
            wbValid = en;
            wbSqN = seqNum_t'(lastSqN + 1 + $urandom_range(WB_SPAN - 1));
        end
    endtask

    always @(posedge clk) begin
        opRec_t                  op;
        expected_t               exp;
        regIdx_t                 rd;
        seqNum_t                 expSqN;
        logic signed [SEQ_W-1:0] sqDiff;
        if (!rst && retValid) begin
            retiredCount++;
            expSqN = lastSqN + 1'b1;
            sqDiff = retSqN - lastSqN;
            if (afterFlush) begin
                if (sqDiff <= 0) begin
                    $display("Sequence number %0d retired again after a flush in test %s",
                             retSqN, testName);
                    errorCount++;
                end
            end else if (retSqN != expSqN) begin
                reportMismatch("retSqN", expSqN, retSqN);
            end
            lastSqN = retSqN;
            afterFlush = 1'b0;
            if (pending.size() == 0) begin
                $display("Operation %0d retired with nothing outstanding in test %s",
                         retSqN, testName);
                errorCount++;
            end else begin
                op = pending.pop_front();
                rd = op.word.regForm.rd;
                exp = predictRetire(op.isImm, op.word);
                if (retRd != rd) begin
                    reportMismatch("retRd", rd, retRd);
                end
                if (retIsImm != op.isImm) begin
                    reportMismatch("retIsImm", op.isImm, retIsImm);
                end
                if (retTagA != exp.tagA) begin
                    reportMismatch("retTagA", exp.tagA, retTagA);
                end
                if (retSrcB != exp.srcB) begin
                    reportMismatch("retSrcB", exp.srcB, retSrcB);
                end
                if (retFreedTag != exp.freed) begin
                    reportMismatch("retFreedTag", exp.freed, retFreedTag);
                end
                if (rd == '0) begin
                    if (retTag != '0) begin
                        reportMismatch("retTag", 0, retTag);
                    end
                end else begin
                    for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                        if (r != rd && refMap[r] == retTag) begin
                            $display("Tag %0d retired for x%0d is still held by x%0d in test %s",
                                     retTag, rd, r, testName);
                            errorCount++;
                        end
                    end
                    refMap[rd] = retTag;
                end
            end
        end
        if (!rst && inValid && inReady && !flush) begin
            pending.push_back({inIsImm, inWord});
        end
        if (flush) begin
            pending.delete();
            afterFlush = 1'b1;
        end
    end

    initial begin
        int accepted;
        int startRetired;
        int assertFails;
        void'($urandom(36));
        rst = 1'b1;
        flush = 1'b0;
        inValid = 1'b0;
        inIsImm = 1'b0;
        inWord = '0;
        wbValid = 1'b0;
        wbSqN = '0;
        wbEnable = 1'b0;
        lastSqN = '1;
        afterFlush = 1'b0;
        errorCount = 0;
        testErrors = 0;
        retiredCount = 0;
        testsRun = 0;
        testsFailed = 0;
        testName = "reset";
        for (int r = 0; r < NUM_ARCH_REGS; r++) begin
            refMap[r] = tag_t'(r);
        end
        fork
            driveWritebacks();
        join_none
        repeat (8) @(negedge clk);
        rst = 1'b0;

        startTest("randomOps");
        wbEnable = 1'b1;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            sendOp(i);
        end
        waitDrain();
        finishTest();

        // Flush a full pipe, then once more with traffic in flight
        startTest("flushRecovery");
        wbEnable = 1'b0;
        floodQueue(accepted);
        applyFlush();
        wbEnable = 1'b1;
        for (int i = 0; i < FLUSH_OPS; i++) begin
            sendOp(i);
        end
        applyFlush();
        for (int i = 0; i < FLUSH_OPS; i++) begin
            sendOp(i);
        end
        waitDrain();
        finishTest();

        startTest("backPressure");
        wbEnable = 1'b0;
        startRetired = retiredCount;
        floodQueue(accepted);
        if (accepted != PIPE_CAPACITY) begin
            reportMismatch("accepted before stall", PIPE_CAPACITY, accepted);
        end
        repeat (4) @(negedge clk);
        if (inReady) begin
            $display("Queue accepted again while writebacks were withheld");
            errorCount++;
        end
        if (retiredCount != startRetired) begin
            reportMismatch("retired while withheld", 0, retiredCount - startRetired);
        end
        wbEnable = 1'b1;
        waitDrain();
        finishTest();

        assertFails = UUT.assertChecker.flushFails + UUT.assertChecker.tagFails
                    + UUT.assertChecker.readyFails;
        $display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 testsRun, testsFailed, errorCount, assertFails);
        if (testsFailed == 0 && errorCount == 0 && assertFails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== dv/renameTop_sva.sv ====
module renameTop_sva import renamePkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input logic    clk,
    input logic    rst,
    input logic    flush,
    input logic    inValid,
    input logic    inReady,
    input logic    decValid,
    input logic    decReady,
    input logic    retValid,
    input regIdx_t retRd,
    input tag_t    retTag,
    input tag_t    retFreedTag
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int COUNT_W = $clog2(QUEUE_DEPTH) + 1;

    int flushFails = 0;
    int tagFails = 0;
    int readyFails = 0;

    logic [COUNT_W-1:0] queueFill;
    logic               queuePush;
    logic               queuePop;

    // Queue occupancy rebuilt from the handshakes on both sides
    assign queuePush = inValid && inReady && !flush;
    assign queuePop = decValid && decReady && !flush;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            queueFill <= '0;
        end else begin
            queueFill <= queueFill + COUNT_W'(queuePush) - COUNT_W'(queuePop);
        end
    end

    // Nothing retires on the flush edge
    retireAfterFlush: assert property (@(posedge clk) disable iff (rst) flush |=> !retValid)
        else begin
            $error("retValid high in the cycle after a flush");
            flushFails++;
        end

    newTagDiffers: assert property (@(posedge clk) disable iff (rst)
        (retValid && retRd != '0) |-> (retTag != retFreedTag))
        else begin
            $error("retired tag equals the tag it releases");
            tagFails++;
        end

    readyWhileRoom: assert property (@(posedge clk) disable iff (rst)
        (queueFill != COUNT_W'(QUEUE_DEPTH)) |-> inReady)
        else begin
            $error("inReady low while the queue has room");
            readyFails++;
        end

endmodule

bind renameTop renameTop_sva #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
) assertChecker (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .inValid    (inValid),
    .inReady    (inReady),
    .decValid   (decBus.valid),
    .decReady   (decBus.ready),
    .retValid   (retValid),
    .retRd      (retRd),
    .retTag     (retTag),
    .retFreedTag(retFreedTag)
);

// ==== hw/renamePkg.sv ====
package renamePkg;

    // Register file sizes
    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_TAGS = 64;

    localparam int REG_W = $clog2(NUM_ARCH_REGS);
    localparam int TAG_W = $clog2(NUM_TAGS);
    localparam int SEQ_W = 6;

    typedef logic [REG_W-1:0] regIdx_t;
    typedef logic [TAG_W-1:0] tag_t;

    // Wraps around, ordering is by signed difference
    typedef logic [SEQ_W-1:0] seqNum_t;

    // Second operand: tag in register form, immediate in immediate form
    typedef logic [TAG_W-1:0] srcB_t;

    // Register form of the decoded word
    typedef struct packed {
        regIdx_t rd;
        regIdx_t rs1;
        regIdx_t rs2;
        logic    pad;
    } regForm_t;

    // Immediate form, rd and rs1 sit in the same bits as in register form
    typedef struct packed {
        regIdx_t    rd;
        regIdx_t    rs1;
        logic [5:0] imm;
    } immForm_t;

    // isImm tells which view holds
    typedef union packed {
        regForm_t regForm;
        immForm_t immForm;
    } opWord_u;

endpackage

// ==== hw/renameStage.sv ====
module renameStage import renamePkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    decodedIf.receiver in,
    renamedIf.producer out,
    input  logic       commitValid,
    input  regIdx_t    commitRd,
    input  tag_t       commitTag
);

    // Tags 0..31 start out holding the architectural registers
    localparam logic [NUM_TAGS-1:0] INIT_TAGS =
        {{(NUM_TAGS - NUM_ARCH_REGS){1'b0}}, {NUM_ARCH_REGS{1'b1}}};

    // Alias table
    tag_t comTag  [NUM_ARCH_REGS];
    tag_t specTag [NUM_ARCH_REGS];

    // Tag pool state
    logic [NUM_TAGS-1:0] tagUsed;
    logic [NUM_TAGS-1:0] tagCommitted;

    seqNum_t counterSqN;

    // Committed view with this cycle's commit applied
    tag_t                comTagNxt [NUM_ARCH_REGS];
    logic [NUM_TAGS-1:0] tagComNxt;
    logic [NUM_TAGS-1:0] usedNxt;

    tag_t    newTag;
    logic    freeAvail;
    regIdx_t inRd;
    srcB_t   srcBNext;
    logic    accept;

    // Output slot
    logic    outValid;
    logic    outIsImm;
    seqNum_t outSqN;
    regIdx_t outRd;
    tag_t    outTagDst;
    tag_t    outTagA;
    srcB_t   outSrcB;

    assign out.valid = outValid;
    assign out.isImm = outIsImm;
    assign out.sqN = outSqN;
    assign out.rd = outRd;
    assign out.tagDst = outTagDst;
    assign out.tagA = outTagA;
    assign out.srcB = outSrcB;

    // Later hits win, so the highest free tag is picked
    always_comb begin
        newTag = '0;
        freeAvail = 1'b0;
        for (int j = 0; j < NUM_TAGS; j++) begin
            if (!tagUsed[j]) begin
                newTag = tag_t'(j);
                freeAvail = 1'b1;
            end
        end
    end

    assign inRd = in.word.regForm.rd;

    // rs2 only means something in register form
    assign srcBNext = in.isImm ? in.word.immForm.imm : specTag[in.word.regForm.rs2];

    // Stall when the slot stays occupied or no tag is left for a real destination
    assign in.ready = (!outValid || out.ready) && (inRd == '0 || freeAvail);
    assign accept = in.valid && in.ready;

    always_comb begin
        comTagNxt = comTag;
        tagComNxt = tagCommitted;
        usedNxt = tagUsed;
        if (commitValid) begin
            // Old committed tag of rd returns to the pool
            tagComNxt[comTag[commitRd]] = 1'b0;
            usedNxt[comTag[commitRd]] = 1'b0;
            tagComNxt[commitTag] = 1'b1;
            usedNxt[commitTag] = 1'b1;
            comTagNxt[commitRd] = commitTag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                comTag[i] <= tag_t'(i);
                specTag[i] <= tag_t'(i);
            end
            tagUsed <= INIT_TAGS;
            tagCommitted <= INIT_TAGS;
            counterSqN <= '0;
            outValid <= 1'b0;
        end else begin
            comTag <= comTagNxt;
            tagCommitted <= tagComNxt;
            if (flush) begin
                // Back to the committed state, including a commit landing now
                specTag <= comTagNxt;
                tagUsed <= tagComNxt;
                outValid <= 1'b0;
            end else begin
                tagUsed <= usedNxt;
                if (accept) begin
                    if (inRd != '0) begin
                        specTag[inRd] <= newTag;
                        tagUsed[newTag] <= 1'b1;
                    end
                    counterSqN <= counterSqN + 1'b1;
                    outValid <= 1'b1;
                end else if (out.ready) begin
                    outValid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outIsImm <= in.isImm;
            outSqN <= counterSqN;
            outRd <= inRd;
            outTagDst <= (inRd != '0) ? newTag : '0;
            outTagA <= specTag[in.word.regForm.rs1];
            outSrcB <= srcBNext;
        end
    end

endmodule

// ==== hw/renameTop.sv ====
module renameTop import renamePkg::*; #(
    parameter int QUEUE_DEPTH = 4,
    parameter int ROB_DEPTH = 8
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,

    // Decoded operations in
    input  logic    inValid,
    input  logic    inIsImm,
    input  opWord_u inWord,
    output logic    inReady,

    // Execution results by sequence number
    input  logic    wbValid,
    input  seqNum_t wbSqN,

    // Retired operations out
    output logic    retValid,
    output seqNum_t retSqN,
    output regIdx_t retRd,
    output tag_t    retTag,
    output tag_t    retFreedTag,
    output tag_t    retTagA,
    output srcB_t   retSrcB,
    output logic    retIsImm
);

    decodedIf decBus ();
    renamedIf renBus ();

    // Commit feedback into the alias table
    logic    commitValid;
    regIdx_t commitRd;
    tag_t    commitTag;

    uopQueue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) queue (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .inValid (inValid),
        .inIsImm (inIsImm),
        .inWord  (inWord),
        .inReady (inReady),
        .out     (decBus)
    );

    renameStage renamer (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .in          (decBus),
        .out         (renBus),
        .commitValid (commitValid),
        .commitRd    (commitRd),
        .commitTag   (commitTag)
    );

    retireBuffer #(
        .ROB_DEPTH(ROB_DEPTH)
    ) rob (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .in          (renBus),
        .wbValid     (wbValid),
        .wbSqN       (wbSqN),
        .commitValid (commitValid),
        .commitRd    (commitRd),
        .commitTag   (commitTag),
        .retValid    (retValid),
        .retSqN      (retSqN),
        .retRd       (retRd),
        .retTag      (retTag),
        .retFreedTag (retFreedTag),
        .retTagA     (retTagA),
        .retSrcB     (retSrcB),
        .retIsImm    (retIsImm)
    );

endmodule

// ==== hw/retireBuffer.sv ====
module retireBuffer import renamePkg::*; #(
    parameter int ROB_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    renamedIf.receiver in,
    input  logic       wbValid,
    input  seqNum_t    wbSqN,
    output logic       commitValid,
    output regIdx_t    commitRd,
    output tag_t       commitTag,
    output logic       retValid,
    output seqNum_t    retSqN,
    output regIdx_t    retRd,
    output tag_t       retTag,
    output tag_t       retFreedTag,
    output tag_t       retTagA,
    output srcB_t      retSrcB,
    output logic       retIsImm
);

    localparam int PTR_W = $clog2(ROB_DEPTH);

    seqNum_t sqNMem    [ROB_DEPTH];
    regIdx_t rdMem     [ROB_DEPTH];
    tag_t    tagDstMem [ROB_DEPTH];
    tag_t    tagAMem   [ROB_DEPTH];
    srcB_t   srcBMem   [ROB_DEPTH];
    logic    isImmMem  [ROB_DEPTH];

    logic [ROB_DEPTH-1:0] entValid;
    logic [ROB_DEPTH-1:0] done;
    logic [PTR_W-1:0]     head;
    logic [PTR_W-1:0]     tail;
    logic [PTR_W:0]       count;

    // Local copy of the committed map, gives the tag being released
    tag_t comShadow [NUM_ARCH_REGS];

    logic    push;
    logic    retire;
    regIdx_t headRd;

    assign in.ready = (count != (PTR_W + 1)'(ROB_DEPTH));
    assign push = in.valid && in.ready && !flush;
    assign retire = entValid[head] && done[head] && !flush;
    assign headRd = rdMem[head];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            entValid <= '0;
            done <= '0;
            retValid <= 1'b0;
            commitValid <= 1'b0;
            if (rst) begin
                for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                    comShadow[i] <= tag_t'(i);
                end
            end
        end else begin
            for (int k = 0; k < ROB_DEPTH; k++) begin
                if (wbValid && entValid[k] && sqNMem[k] == wbSqN) begin
                    done[k] <= 1'b1;
                end
            end
            if (push) begin
                // A writeback arriving together with its op still counts
                entValid[tail] <= 1'b1;
                done[tail] <= wbValid && (wbSqN == in.sqN);
                tail <= tail + 1'b1;
            end
            if (retire) begin
                entValid[head] <= 1'b0;
                done[head] <= 1'b0;
                head <= head + 1'b1;
                if (headRd != '0) begin
                    comShadow[headRd] <= tagDstMem[head];
                end
            end
            retValid <= retire;
            commitValid <= retire && (headRd != '0);
            case ({push, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            sqNMem[tail] <= in.sqN;
            rdMem[tail] <= in.rd;
            tagDstMem[tail] <= in.tagDst;
            tagAMem[tail] <= in.tagA;
            srcBMem[tail] <= in.srcB;
            isImmMem[tail] <= in.isImm;
        end
        if (retire) begin
            retSqN <= sqNMem[head];
            retRd <= headRd;
            retTagA <= tagAMem[head];
            retSrcB <= srcBMem[head];
            retIsImm <= isImmMem[head];
            commitRd <= headRd;
            commitTag <= tagDstMem[head];
            // x0 writes neither allocate nor release a tag
            retTag <= (headRd != '0) ? tagDstMem[head] : '0;
            retFreedTag <= (headRd != '0) ? comShadow[headRd] : '0;
        end
    end

endmodule

// ==== hw/stageIf.sv ====
// Decoded operation from the queue into rename
interface decodedIf import renamePkg::*; ();
    logic    valid;
    logic    isImm;
    opWord_u word;
    logic    ready;

    modport producer (output valid, isImm, word, input ready);
    modport receiver (input valid, isImm, word, output ready);
endinterface

// Renamed operation from rename into the retire buffer
interface renamedIf import renamePkg::*; ();
    logic    valid;
    logic    isImm;
    seqNum_t sqN;
    regIdx_t rd;
    tag_t    tagDst;
    tag_t    tagA;
    srcB_t   srcB;
    logic    ready;

    modport producer (
        output valid, isImm, sqN, rd, tagDst, tagA, srcB,
        input  ready
    );
    modport receiver (
        input  valid, isImm, sqN, rd, tagDst, tagA, srcB,
        output ready
    );
endinterface

// ==== hw/uopQueue.sv ====
module uopQueue import renamePkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       inValid,
    input  logic       inIsImm,
    input  opWord_u    inWord,
    output logic       inReady,
    decodedIf.producer out
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    logic    isImmMem [QUEUE_DEPTH];
    opWord_u wordMem  [QUEUE_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;

    logic push;
    logic pop;

    assign inReady = (count != (PTR_W + 1)'(QUEUE_DEPTH));

    // Anything arriving on a flush edge is dropped with the rest
    assign push = inValid && inReady && !flush;
    assign pop = out.valid && out.ready && !flush;

    // Oldest entry is shown straight from storage
    assign out.valid = (count != '0);
    assign out.isImm = isImmMem[head];
    assign out.word = wordMem[head];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            isImmMem[tail] <= inIsImm;
            wordMem[tail] <= inWord;
        end
    end

endmodule
